// File: time_sync_pkg.sv
package time_sync_pkg;

   // control word layout, bit 0 is tick_source.
   typedef struct packed {
      logic [26:0] reserved;
      logic        sync_every_pps;   // zero the counter on every pps edge.
      logic        pps_edge;         // 1 picks the rising-edge pps input.
      logic        external_sync;    // load time from the serial link.
      logic        tick_int_enable;
      logic        tick_source;      // 1 ticks on pps, 0 on the interval.
   } ts_ctrl_t;

   // the same write data is read as a plain value or as the control word.
   typedef union packed {
      logic [31:0] raw;
      ts_ctrl_t    ctrl;
   } ts_wr_word_u;

   // configuration handed from the register block to the core.
   typedef struct packed {
      ts_ctrl_t    ctrl;
      logic [31:0] tick_interval;
      logic [31:0] delta_time;
      logic        arm_sync;         // one-cycle pulse.
   } ts_cfg_t;

   // time word recovered from the serial link.
   typedef struct packed {
      logic        valid;
      logic [31:0] time_word;
   } ts_frame_t;

   // register map, word addresses.
   localparam logic [2:0] REG_CTRL     = 3'd0;
   localparam logic [2:0] REG_INTERVAL = 3'd1;
   localparam logic [2:0] REG_DELTA    = 3'd2;
   localparam logic [2:0] REG_ARM      = 3'd3;

   // serial frame.
   localparam int FRAME_BITS   = 32;
   localparam int LINK_LATENCY = 35;  // send to load, in cycles.

endpackage

// File: time_sync_regs.sv
`timescale 1ns/10ps

module time_sync_regs
#(
   parameter logic [31:0] DEFAULT_INTERVAL = 32'd99999
)
(
   input  logic                    sys_clk_i,
   input  logic                    rst_i,
   input  logic                    cyc_i,
   input  logic                    stb_i,
   input  logic                    we_i,
   input  logic [2:0]              adr_i,
   input  logic [31:0]             dat_i,
   output logic [31:0]             dat_o,
   output logic                    ack_o,
   input  logic [31:0]             tick_time_i,
   output time_sync_pkg::ts_cfg_t  cfg_o
);

   time_sync_pkg::ts_wr_word_u wr_word;
   time_sync_pkg::ts_ctrl_t    ctrl_q;
   logic [31:0]                interval_q;
   logic [31:0]                delta_q;
   logic                       arm_q;
   logic                       wr_en;

   // classic cycle, no wait states.
   assign ack_o   = cyc_i & stb_i;
   assign wr_en   = cyc_i & stb_i & we_i;
   assign wr_word = dat_i;

   always_ff @(posedge sys_clk_i)
   begin
      if (rst_i)
      begin
         ctrl_q     <= '0;
         interval_q <= DEFAULT_INTERVAL;
         delta_q    <= '0;
         arm_q      <= 1'b0;
      end
      else
      begin
         arm_q <= 1'b0;  // pulse lasts one cycle.
         if (wr_en)
         begin
            case (adr_i)
               time_sync_pkg::REG_CTRL:     ctrl_q     <= wr_word.ctrl;
               time_sync_pkg::REG_INTERVAL: interval_q <= wr_word.raw;
               time_sync_pkg::REG_DELTA:    delta_q    <= wr_word.raw;
               time_sync_pkg::REG_ARM:      arm_q      <= 1'b1;  // data is ignored.
               default:
               begin
               end
            endcase
         end
      end
   end

   assign cfg_o.ctrl          = ctrl_q;
   assign cfg_o.tick_interval = interval_q;
   assign cfg_o.delta_time    = delta_q;
   assign cfg_o.arm_sync      = arm_q;

   // only the time captured at the last tick can be read.
   assign dat_o = tick_time_i;

endmodule

// File: time_sync_core.sv
`timescale 1ns/10ps

module time_sync_core
#(
   parameter int EPOCH_BITS = 28
)
(
   input  logic                      sys_clk_i,
   input  logic                      rst_i,
   input  time_sync_pkg::ts_cfg_t    cfg_i,
   input  time_sync_pkg::ts_frame_t  rx_frame_i,
   input  logic                      pps_pos_i,
   input  logic                      pps_neg_i,
   output logic [31:0]               master_time_o,
   output logic                      send_sync_o,
   output logic [31:0]               tick_time_o,
   output logic                      int_o,
   output logic                      epoch_o,
   output logic                      pps_o
);

   logic        pps_sel;
   logic        pps_d1;
   logic        pps_d2;
   logic        pps_ext;
   logic        sync_armed;
   logic        clear_on_pps;
   logic        load_rx;
   logic [31:0] interval_cnt;
   logic        tick_free_run;
   logic        internal_tick;

   // pick the pps polarity, then two flops before the edge detect.
   assign pps_sel = cfg_i.ctrl.pps_edge ? pps_pos_i : pps_neg_i;

   always_ff @(posedge sys_clk_i)
   begin
      if (rst_i)
      begin
         pps_d1 <= 1'b0;
         pps_d2 <= 1'b0;
      end
      else
      begin
         pps_d1 <= pps_sel;
         pps_d2 <= pps_d1;
      end
   end

   assign pps_ext = pps_d1 & ~pps_d2;

   // armed by a write to the arm register, spent by the next pps edge.
   always_ff @(posedge sys_clk_i)
   begin
      if (rst_i)
         sync_armed <= 1'b0;
      else if (pps_ext)
         sync_armed <= 1'b0;
      else if (cfg_i.arm_sync)
         sync_armed <= 1'b1;
   end

   assign load_rx      = cfg_i.ctrl.external_sync & rx_frame_i.valid;
   assign clear_on_pps = pps_ext & (sync_armed | cfg_i.ctrl.sync_every_pps);

   // master time, a received frame wins over a pps clear.
   always_ff @(posedge sys_clk_i)
   begin
      if (rst_i)
         master_time_o <= '0;
      else if (load_rx)
         master_time_o <= rx_frame_i.time_word + cfg_i.delta_time;
      else if (clear_on_pps)
         master_time_o <= '0;
      else
         master_time_o <= master_time_o + 32'd1;
   end

   // free-running interval, one tick every tick_interval+1 cycles.
   always_ff @(posedge sys_clk_i)
   begin
      if (rst_i || tick_free_run)
         interval_cnt <= '0;
      else
         interval_cnt <= interval_cnt + 32'd1;
   end

   assign tick_free_run = (interval_cnt >= cfg_i.tick_interval);

   always_ff @(posedge sys_clk_i)
   begin
      if (rst_i)
      begin
         internal_tick <= 1'b0;
         int_o         <= 1'b0;
         pps_o         <= 1'b0;
         epoch_o       <= 1'b0;
      end
      else
      begin
         internal_tick <= cfg_i.ctrl.tick_source ? pps_ext : tick_free_run;
         int_o         <= cfg_i.ctrl.tick_int_enable & internal_tick;
         pps_o         <= pps_ext;
         epoch_o       <= (master_time_o[EPOCH_BITS-1:0] == '0);
      end
   end

   // time seen in the tick cycle, read back over the bus.
   always_ff @(posedge sys_clk_i)
   begin
      if (internal_tick)
         tick_time_o <= master_time_o;
   end

   assign send_sync_o = internal_tick;  // the tick also starts a frame.

endmodule

// File: time_sender.sv
`timescale 1ns/10ps

module time_sender
(
   input  logic        sys_clk_i,
   input  logic        rst_i,
   input  logic [31:0] master_time_i,
   input  logic        send_sync_i,
   output logic        exp_pps_o
);

   localparam int CNT_W = $clog2(time_sync_pkg::FRAME_BITS + 1);

   logic [time_sync_pkg::FRAME_BITS-1:0] shift_q;
   logic [CNT_W-1:0]                     bit_cnt;
   logic                                 busy;

   // start bit, then FRAME_BITS data bits msb first; line idles high.
   always_ff @(posedge sys_clk_i)
   begin
      if (rst_i)
      begin
         exp_pps_o <= 1'b1;
         busy      <= 1'b0;
         bit_cnt   <= '0;
      end
      else if (!busy)
      begin
         if (send_sync_i)
         begin
            exp_pps_o <= 1'b0;  // start bit.
            busy      <= 1'b1;
            bit_cnt   <= '0;
         end
      end
      else if (bit_cnt == CNT_W'(time_sync_pkg::FRAME_BITS))
      begin
         exp_pps_o <= 1'b1;  // back to idle.
         busy      <= 1'b0;
      end
      else
      begin
         exp_pps_o <= shift_q[time_sync_pkg::FRAME_BITS-1];
         bit_cnt   <= bit_cnt + 1'b1;
      end
   end

   // payload shift register.
   always_ff @(posedge sys_clk_i)
   begin
      if (!busy && send_sync_i)
         shift_q <= master_time_i;  // latch the time on the tick.
      else if (busy)
         shift_q <= {shift_q[time_sync_pkg::FRAME_BITS-2:0], 1'b0};
   end

endmodule

// File: time_receiver.sv
`timescale 1ns/10ps

module time_receiver
(
   input  logic                      sys_clk_i,
   input  logic                      rst_i,
   input  logic                      exp_pps_i,
   output time_sync_pkg::ts_frame_t  rx_frame_o
);

   localparam int CNT_W = $clog2(time_sync_pkg::FRAME_BITS);

   logic [time_sync_pkg::FRAME_BITS-1:0] shift_q;
   logic [CNT_W-1:0]                     bit_cnt;
   logic                                 busy;
   logic                                 last_bit;
   logic                                 frame_valid;
   logic [31:0]                          frame_word;

   assign last_bit = busy && (bit_cnt == CNT_W'(time_sync_pkg::FRAME_BITS - 1));

   // idle until a low start bit, then count the data bits.
   always_ff @(posedge sys_clk_i)
   begin
      if (rst_i)
      begin
         busy        <= 1'b0;
         bit_cnt     <= '0;
         frame_valid <= 1'b0;
      end
      else
      begin
         frame_valid <= last_bit;  // one-cycle strobe.
         if (!busy)
         begin
            if (!exp_pps_i)
            begin
               busy    <= 1'b1;
               bit_cnt <= '0;
            end
         end
         else
         begin
            bit_cnt <= bit_cnt + 1'b1;
            if (last_bit)
               busy <= 1'b0;
         end
      end
   end

   // data bits arrive msb first.
   always_ff @(posedge sys_clk_i)
   begin
      if (busy)
         shift_q <= {shift_q[time_sync_pkg::FRAME_BITS-2:0], exp_pps_i};
      if (last_bit)
         frame_word <= {shift_q[time_sync_pkg::FRAME_BITS-2:0], exp_pps_i};
   end

   assign rx_frame_o.valid     = frame_valid;
   assign rx_frame_o.time_word = frame_word;

endmodule

// File: time_sync_top.sv
`timescale 1ns/10ps

module time_sync_top
#(
   parameter logic [31:0] DEFAULT_INTERVAL = 32'd99999,
   parameter int          EPOCH_BITS       = 28
)
(
   input  logic        sys_clk_i,
   input  logic        rst_i,
   input  logic        cyc_i,
   input  logic        stb_i,
   input  logic        we_i,
   input  logic [2:0]  adr_i,
   input  logic [31:0] dat_i,
   output logic [31:0] dat_o,
   output logic        ack_o,
   input  logic        pps_pos_i,
   input  logic        pps_neg_i,
   input  logic        exp_pps_i,
   output logic        exp_pps_o,
   output logic [31:0] master_time_o,
   output logic        int_o,
   output logic        epoch_o,
   output logic        pps_o
);

   time_sync_pkg::ts_cfg_t   cfg;
   time_sync_pkg::ts_frame_t rx_frame;
   logic [31:0]              tick_time;
   logic                     send_sync;

   time_sync_regs #(
      .DEFAULT_INTERVAL (DEFAULT_INTERVAL)
   ) regs_i (
      .sys_clk_i   (sys_clk_i),
      .rst_i       (rst_i),
      .cyc_i       (cyc_i),
      .stb_i       (stb_i),
      .we_i        (we_i),
      .adr_i       (adr_i),
      .dat_i       (dat_i),
      .dat_o       (dat_o),
      .ack_o       (ack_o),
      .tick_time_i (tick_time),
      .cfg_o       (cfg)
   );

   time_sync_core #(
      .EPOCH_BITS (EPOCH_BITS)
   ) core_i (
      .sys_clk_i     (sys_clk_i),
      .rst_i         (rst_i),
      .cfg_i         (cfg),
      .rx_frame_i    (rx_frame),
      .pps_pos_i     (pps_pos_i),
      .pps_neg_i     (pps_neg_i),
      .master_time_o (master_time_o),
      .send_sync_o   (send_sync),
      .tick_time_o   (tick_time),
      .int_o         (int_o),
      .epoch_o       (epoch_o),
      .pps_o         (pps_o)
   );

   time_sender sender_i (
      .sys_clk_i     (sys_clk_i),
      .rst_i         (rst_i),
      .master_time_i (master_time_o),
      .send_sync_i   (send_sync),
      .exp_pps_o     (exp_pps_o)
   );

   time_receiver receiver_i (
      .sys_clk_i  (sys_clk_i),
      .rst_i      (rst_i),
      .exp_pps_i  (exp_pps_i),
      .rx_frame_o (rx_frame)
   );

endmodule

// File: time_sync_assert.sv
`timescale 1ns/10ps

module time_sync_assert
#(
   parameter int EPOCH_BITS = 28
)
(
   input logic        sys_clk_i,
   input logic        rst_i,
   input logic        cyc_i,
   input logic        stb_i,
   input logic        ack_o,
   input logic        pps_pos_i,
   input logic        pps_neg_i,
   input logic        exp_pps_o,
   input logic [31:0] master_time_o,
   input logic        int_o,
   input logic        epoch_o,
   input logic        pps_o
);

   ack_follows_stb: assert property (@(posedge sys_clk_i) ack_o == (cyc_i && stb_i))
      else $error("ack_o does not follow cyc_i and stb_i");

   // outputs quiet and serial line idle once reset has been seen.
   idle_after_reset: assert property (@(posedge sys_clk_i)
      rst_i |=> (!int_o && !epoch_o && !pps_o && exp_pps_o))
      else $error("outputs not idle after reset");

   int_single_cycle: assert property (@(posedge sys_clk_i) disable iff (rst_i)
      int_o |=> !int_o)
      else $error("int_o held for more than one cycle");

   // pps_o comes two cycles after an input rises.
   pps_after_edge: assert property (@(posedge sys_clk_i) disable iff (rst_i)
      pps_o |-> (($past(pps_pos_i, 2) && !$past(pps_pos_i, 3)) ||
                 ($past(pps_neg_i, 2) && !$past(pps_neg_i, 3))))
      else $error("pps_o without a pps input edge two cycles before");

   epoch_after_zero: assert property (@(posedge sys_clk_i) disable iff (rst_i)
      !$past(rst_i) |-> (epoch_o == ($past(master_time_o[EPOCH_BITS-1:0]) == '0)))
      else $error("epoch_o does not follow a zero in the low time bits");

endmodule

bind time_sync_top time_sync_assert #(
   .EPOCH_BITS (EPOCH_BITS)
) assert_i (
   .sys_clk_i     (sys_clk_i),
   .rst_i         (rst_i),
   .cyc_i         (cyc_i),
   .stb_i         (stb_i),
   .ack_o         (ack_o),
   .pps_pos_i     (pps_pos_i),
   .pps_neg_i     (pps_neg_i),
   .exp_pps_o     (exp_pps_o),
   .master_time_o (master_time_o),
   .int_o         (int_o),
   .epoch_o       (epoch_o),
   .pps_o         (pps_o)
);

// File: tb_time_sync.sv
`timescale 1ns/10ps

module tb_time_sync;

   localparam int EPOCH_BITS      = 28;
   localparam int MIN_INTERVAL    = 40;
   localparam int MAX_INTERVAL    = 200;
   localparam int PPS_GAP         = 12;   // cycles per pps pulse with 3 of them high.
   localparam int FRAMES_PER_RUN  = 6;
   localparam int TEST_CYCLES     = 60 + 5 * (MAX_INTERVAL + 1) + 10 + 8 * PPS_GAP + 20
                                  + 3 * PPS_GAP + 10
                                  + 2 * (FRAMES_PER_RUN * (MAX_INTERVAL + 1) + 10);
   localparam int WATCHDOG_CYCLES = TEST_CYCLES * 12 / 10;

   logic        sys_clk_i;
   logic        rst_i;
   logic        cyc_i;
   logic        stb_i;
   logic        we_i;
   logic [2:0]  adr_i;
   logic [31:0] dat_i;
   logic [31:0] dat_o;
   logic        ack_o;
   logic        pps_pos_i;
   logic        pps_neg_i;
   logic        serial_line;              // loopback of the time link.
   logic [31:0] master_time_o;
   logic        int_o;
   logic        epoch_o;
   logic        pps_o;

   // reference model state holding the values of the current cycle.
   time_sync_pkg::ts_ctrl_t m_ctrl;
   logic [31:0] m_interval;
   logic [31:0] m_delta;
   logic [31:0] m_time;
   logic [31:0] m_icnt;
   logic [31:0] m_tick_time;
   logic [31:0] m_rx_time;
   logic        m_p1;
   logic        m_p2;
   logic        m_armed;
   logic        m_arm_pulse;
   logic        m_tick;
   logic        m_int;
   logic        m_pps;
   logic        m_epoch;
   int          m_cycle;
   int          m_rx_cycle;
   int          m_tx_free;

   int          check_errors = 0;
   int          test_base    = 0;
   int          test_count   = 0;
   int          failed_tests = 0;
   int unsigned seed_draw;

   time_sync_top #(
      .DEFAULT_INTERVAL (32'd99999)
   ) dut_i (
      .sys_clk_i     (sys_clk_i),
      .rst_i         (rst_i),
      .cyc_i         (cyc_i),
      .stb_i         (stb_i),
      .we_i          (we_i),
      .adr_i         (adr_i),
      .dat_i         (dat_i),
      .dat_o         (dat_o),
      .ack_o         (ack_o),
      .pps_pos_i     (pps_pos_i),
      .pps_neg_i     (pps_neg_i),
      .exp_pps_i     (serial_line),
      .exp_pps_o     (serial_line),
      .master_time_o (master_time_o),
      .int_o         (int_o),
      .epoch_o       (epoch_o),
      .pps_o         (pps_o)
   );

   initial
   begin
      sys_clk_i = 1'b0;
      forever #50 sys_clk_i = ~sys_clk_i;
   end

   task automatic flag_mismatch(input string what, input logic [31:0] got,
                                input logic [31:0] want);
      check_errors++;
      $display("mismatch at %0d ns: %s is %h, expected %h", $time, what, got, want);
   endtask

   // advance n cycles and stop 10 ns after a rising edge.
   task automatic step(input int n);
      repeat (n) @(posedge sys_clk_i);
      #10;
   endtask

   task automatic bus_write(input logic [2:0] adr, input logic [31:0] data);
      cyc_i = 1'b1;
      stb_i = 1'b1;
      we_i  = 1'b1;
      adr_i = adr;
      dat_i = data;
      step(1);
      cyc_i = 1'b0;
      stb_i = 1'b0;
      we_i  = 1'b0;
   endtask

   task automatic bus_read();
      cyc_i = 1'b1;
      stb_i = 1'b1;
      step(1);
      cyc_i = 1'b0;
      stb_i = 1'b0;
   endtask

   task automatic pps_pulse(input logic rising);
      if (rising)
         pps_pos_i = 1'b1;
      else
         pps_neg_i = 1'b1;
      step(3);
      pps_pos_i = 1'b0;
      pps_neg_i = 1'b0;
      step(PPS_GAP - 3);
   endtask

   task automatic end_test(input string name);
      int errs;
      errs = check_errors - test_base;
      test_count++;
      if (errs == 0)
         $display("test %0d, %s: passed", test_count, name);
      else
      begin
         failed_tests++;
         $display("test %0d, %s: failed with %0d errors", test_count, name, errs);
      end
      test_base = check_errors;
   endtask

   // compare the outputs and then step the model over this edge.
   always @(posedge sys_clk_i)
   begin : model_step
      logic pps_in;
      logic pps_edge_now;
      logic tick_free;
      logic load_now;
      logic [31:0] load_time;
      if (rst_i)
      begin
         m_ctrl      = '0;
         m_interval  = 32'd99999;
         m_delta     = '0;
         m_time      = '0;
         m_icnt      = '0;
         {m_p1, m_p2, m_armed, m_arm_pulse, m_tick, m_int, m_pps, m_epoch} = '0;
         m_cycle     = 0;
         m_rx_cycle  = -1;
         m_tx_free   = 0;
      end
      else
      begin
         assert (master_time_o == m_time) else flag_mismatch("master_time_o", master_time_o, m_time);
         assert (int_o == m_int) else flag_mismatch("int_o", 32'(int_o), 32'(m_int));
         assert (pps_o == m_pps) else flag_mismatch("pps_o", 32'(pps_o), 32'(m_pps));
         assert (epoch_o == m_epoch) else flag_mismatch("epoch_o", 32'(epoch_o), 32'(m_epoch));
         assert (ack_o == (cyc_i && stb_i))
            else flag_mismatch("ack_o", 32'(ack_o), 32'(cyc_i && stb_i));
         if (m_int)
         begin
            assert (dat_o == m_tick_time) else flag_mismatch("dat_o", dat_o, m_tick_time);
         end

         pps_in       = m_ctrl.pps_edge ? pps_pos_i : pps_neg_i;
         pps_edge_now = m_p1 && !m_p2;
         tick_free    = (m_icnt >= m_interval);
         load_now     = m_ctrl.external_sync && (m_cycle == m_rx_cycle);
         load_time    = m_rx_time + m_delta;  // word of the frame arriving in this cycle.

         // a tick captures the time and starts a frame if the link is free.
         if (m_tick)
         begin
            m_tick_time = m_time;
            if (m_cycle >= m_tx_free)
            begin
               m_rx_time  = m_time;
               m_rx_cycle = m_cycle + 34;
               m_tx_free  = m_cycle + 34;
            end
         end
         m_int   = m_ctrl.tick_int_enable && m_tick;
         m_epoch = (m_time[EPOCH_BITS-1:0] == '0);
         m_pps   = pps_edge_now;
         m_tick  = m_ctrl.tick_source ? pps_edge_now : tick_free;
         m_icnt  = tick_free ? 32'd0 : m_icnt + 32'd1;
         if (load_now)
            m_time = load_time;
         else if (pps_edge_now && (m_armed || m_ctrl.sync_every_pps))
            m_time = '0;
         else
            m_time = m_time + 32'd1;
         if (pps_edge_now)
            m_armed = 1'b0;
         else if (m_arm_pulse)
            m_armed = 1'b1;
         m_p2 = m_p1;
         m_p1 = pps_in;

         m_arm_pulse = 1'b0;  // bus writes land for the next cycle.
         if (cyc_i && stb_i && we_i)
         begin
            case (adr_i)
               time_sync_pkg::REG_CTRL:     m_ctrl      = dat_i;
               time_sync_pkg::REG_INTERVAL: m_interval  = dat_i;
               time_sync_pkg::REG_DELTA:    m_delta     = dat_i;
               time_sync_pkg::REG_ARM:      m_arm_pulse = 1'b1;
               default:
               begin
               end
            endcase
         end
         m_cycle++;
      end
   end

   initial
   begin
      repeat (WATCHDOG_CYCLES) @(posedge sys_clk_i);
      $display("timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
      $display("ERRORS FOUND");
      $finish;
   end

   initial
   begin
      logic [31:0]             ival;
      logic [31:0]             dval;
      time_sync_pkg::ts_ctrl_t ctrl;
      rst_i     = 1'b1;
      cyc_i     = 1'b0;
      stb_i     = 1'b0;
      we_i      = 1'b0;
      adr_i     = '0;
      dat_i     = '0;
      pps_pos_i = 1'b0;
      pps_neg_i = 1'b0;
      seed_draw = $urandom(11578);
      step(5);
      rst_i = 1'b0;

      // reset values, bus handshake, plain counting.
      step(10);
      bus_read();
      cyc_i = 1'b1;  // cycle without strobe.
      step(1);
      cyc_i = 1'b0;
      step(30);
      end_test("reset and bus");

      ival = 32'(MIN_INTERVAL) + ($urandom % 32'(MAX_INTERVAL - MIN_INTERVAL + 1));
      bus_write(time_sync_pkg::REG_INTERVAL, ival);
      ctrl = '0;
      ctrl.tick_int_enable = 1'b1;
      bus_write(time_sync_pkg::REG_CTRL, ctrl);
      step(5 * (int'(ival) + 1));
      end_test("free-running tick");

      ctrl = '0;
      ctrl.tick_source     = 1'b1;
      ctrl.tick_int_enable = 1'b1;
      for (int pol = 0; pol < 2; pol++)
      begin
         ctrl.pps_edge = pol[0];
         bus_write(time_sync_pkg::REG_CTRL, ctrl);
         pps_pulse(pol[0]);
         bus_write(time_sync_pkg::REG_ARM, 32'hffff_ffff);
         pps_pulse(pol[0]);  // the armed sync clears the count.
         pps_pulse(pol[0]);
      end
      end_test("pps tick and armed sync");

      ctrl = '0;
      ctrl.sync_every_pps = 1'b1;
      ctrl.pps_edge       = 1'b1;
      bus_write(time_sync_pkg::REG_CTRL, ctrl);
      repeat (3) pps_pulse(1'b1);
      end_test("sync on every pps");

      ival = 32'(MIN_INTERVAL) + ($urandom % 32'(MAX_INTERVAL - MIN_INTERVAL + 1));
      bus_write(time_sync_pkg::REG_INTERVAL, ival);
      bus_write(time_sync_pkg::REG_DELTA, 32'(time_sync_pkg::LINK_LATENCY));
      ctrl = '0;
      ctrl.external_sync   = 1'b1;
      ctrl.tick_int_enable = 1'b1;
      bus_write(time_sync_pkg::REG_CTRL, ctrl);
      step(FRAMES_PER_RUN * (int'(ival) + 1));
      dval = 32'(time_sync_pkg::LINK_LATENCY) + 32'd1 + ($urandom % 32'd1000);
      bus_write(time_sync_pkg::REG_DELTA, dval);  // each frame now jumps ahead.
      step(FRAMES_PER_RUN * (int'(ival) + 1));
      end_test("loopback sync");

      $display("summary: %0d tests, %0d failed, %0d check errors",
               test_count, failed_tests, check_errors);
      if (check_errors == 0)
         $display("NO ERRORS");
      else
         $display("ERRORS FOUND");
      $finish;
   end

endmodule

// File: compile.f
time_sync_pkg.sv
time_sync_regs.sv
time_sync_core.sv
time_sender.sv
time_receiver.sv
time_sync_top.sv
time_sync_assert.sv
tb_time_sync.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the time sync testbench with verilator.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_time_sync -f compile.f \
   --Mdir "$BUILD_DIR" -o sim_tb
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

"./$BUILD_DIR/sim_tb" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if grep -qx "NO ERRORS" "$LOG_FILE"; then
   echo "simulation passed"
   exit 0
else
   echo "simulation failed"
   exit 1
fi
